//--- spi_pkg.sv
`default_nettype none

package spi_pkg;

    // fifo geometry, shared by both directions
    localparam int LOG2_FIFO_DEPTH = 4;                  // 16 entries
    localparam int FIFO_DBITS = 8;
    localparam int FIFO_CNT_BITS = LOG2_FIFO_DEPTH + 1;  // room for the full count

    // count value of a full fifo
    localparam logic [FIFO_CNT_BITS-1:0] FIFO_DEPTH = FIFO_CNT_BITS'(1 << LOG2_FIFO_DEPTH);

    // register word index, paddr[11:2]
    localparam logic [9:0] REG_SCKDIV = 10'h000;         // 0x00
    localparam logic [9:0] REG_TXCTRL = 10'h011;         // 0x44
    localparam logic [9:0] REG_TXDATA = 10'h012;         // 0x48
    localparam logic [9:0] REG_RXDATA = 10'h013;         // 0x4c
    localparam logic [9:0] REG_CRC16 = 10'h016;          // 0x58

    // transmit engine states, visible in txctrl[5:4]
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        WAIT_EDGE = 2'd1,   // byte loaded, waiting for a falling sclk
        SEND_DATA = 2'd2,
        ENDING    = 2'd3    // last bit out, cs drops on next fall
    } spi_state_e;

endpackage

`default_nettype wire

//--- sfifo.sv
`default_nettype none

module sfifo (
    input  logic                              i_clk,
    input  logic                              i_nrst,
    input  logic                              i_we,
    input  logic [spi_pkg::FIFO_DBITS-1:0]    i_wdata,
    input  logic                              i_re,
    output logic [spi_pkg::FIFO_DBITS-1:0]    o_rdata,
    output logic [spi_pkg::FIFO_CNT_BITS-1:0] o_count
);

    logic [spi_pkg::FIFO_DBITS-1:0] mem [spi_pkg::FIFO_DEPTH];
    logic [spi_pkg::LOG2_FIFO_DEPTH-1:0] wr_ptr;
    logic [spi_pkg::LOG2_FIFO_DEPTH-1:0] rd_ptr;
    logic [spi_pkg::FIFO_CNT_BITS-1:0] count;
    logic wr_ok;
    logic rd_ok;

    // drop writes when full, ignore reads when empty
    assign wr_ok = i_we && (count != spi_pkg::FIFO_DEPTH);
    assign rd_ok = i_re && (count != '0);

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;   // idle or push and pop together
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= i_wdata;
        end
    end

    assign o_rdata = mem[rd_ptr];  // head, valid in the pop cycle
    assign o_count = count;

    a_count_bound: assert property (@(posedge i_clk) disable iff (!i_nrst)
        count <= spi_pkg::FIFO_DEPTH);

endmodule

`default_nettype wire

//--- apb_slv.sv
`default_nettype none

module apb_slv (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_psel,
    input  logic        i_penable,
    input  logic        i_pwrite,
    input  logic [31:0] i_paddr,
    input  logic [31:0] i_pwdata,
    output logic [31:0] o_prdata,
    output logic        o_pready,
    output logic        o_pslverr,
    output logic        o_req_valid,
    output logic [31:0] o_req_addr,
    output logic        o_req_write,
    output logic [31:0] o_req_wdata,
    input  logic        i_resp_valid,
    input  logic [31:0] i_resp_rdata,
    input  logic        i_resp_err
);

    logic pending;   // request issued, response not yet seen

    // one request per access phase
    assign o_req_valid = i_psel && i_penable && !pending;
    assign o_req_addr = i_paddr;
    assign o_req_write = i_pwrite;
    assign o_req_wdata = i_pwdata;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            pending <= 1'b0;
        end else if (o_req_valid) begin
            pending <= 1'b1;
        end else if (i_resp_valid) begin
            pending <= 1'b0;
        end
    end

    // response completes the transfer
    assign o_pready = i_resp_valid;
    assign o_prdata = i_resp_rdata;
    assign o_pslverr = i_resp_valid && i_resp_err;

    // completion only while the master still selects us
    a_pready_psel: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_pready |-> i_psel);

endmodule

`default_nettype wire

//--- spi_engine.sv
`default_nettype none

module spi_engine (
    input  logic                              i_clk,
    input  logic                              i_nrst,
    input  logic                              i_scaler_wr,
    input  logic [31:0]                       i_scaler,
    input  logic                              i_txctrl_wr,
    input  logic [15:0]                       i_byte_cnt,
    input  logic                              i_gen_crc,
    input  logic                              i_crc16_wr,
    input  logic [15:0]                       i_crc16_wdata,
    output logic [15:0]                       o_byte_cnt,
    output logic                              o_gen_crc,
    output spi_pkg::spi_state_e               o_state,
    output logic [15:0]                       o_crc16,
    output logic                              o_txfifo_re,
    input  logic [spi_pkg::FIFO_DBITS-1:0]    i_txfifo_rdata,
    input  logic [spi_pkg::FIFO_CNT_BITS-1:0] i_txfifo_count,
    output logic                              o_rxfifo_we,
    output logic [spi_pkg::FIFO_DBITS-1:0]    o_rxfifo_wdata,
    output logic                              o_spi_cs_n,
    output logic                              o_spi_sclk,
    output logic                              o_spi_mosi,
    input  logic                              i_spi_miso
);

    logic [31:0] scaler;
    logic [31:0] scaler_cnt;
    logic level;                 // free running serial clock level
    logic cs;
    spi_pkg::spi_state_e state;
    logic [15:0] byte_cnt;
    logic gen_crc;
    logic [2:0] bit_cnt;
    logic [7:0] tx_val;          // next byte to send
    logic [7:0] tx_shift;
    logic [7:0] rx_shift;
    logic rx_ready;
    logic [6:0] crc7;
    logic [6:0] crc7_nxt;
    logic [15:0] crc16;
    logic [15:0] crc16_nxt;
    logic fb7;
    logic fb16;
    logic tick;
    logic sclk_rise;
    logic sclk_fall;
    logic last_bit;
    logic fetch;
    logic [7:0] fetch_byte;

    always_comb begin
        tick = (scaler != '0) && (scaler_cnt == scaler - 32'd1);
        sclk_rise = tick && !level;
        sclk_fall = tick && level;
        last_bit = (state == spi_pkg::SEND_DATA) && (bit_cnt == 3'd0) && sclk_rise;
        // pop a byte at burst start and after each byte while count remains
        fetch = (byte_cnt != '0) && ((state == spi_pkg::IDLE) || last_bit);
        fetch_byte = (i_txfifo_count == '0) ? 8'hff : i_txfifo_rdata;  // idle line if empty

        // crc7, x^7 + x^3 + 1, over mosi
        fb7 = crc7[6] ^ tx_shift[7];
        crc7_nxt = {crc7[5:3], crc7[2] ^ fb7, crc7[1:0], fb7};

        // crc16, x^16 + x^12 + x^5 + 1, over miso
        fb16 = crc16[15] ^ i_spi_miso;
        crc16_nxt = {crc16[14:12], crc16[11] ^ fb16, crc16[10:5], crc16[4] ^ fb16,
                     crc16[3:0], fb16};
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            scaler <= '0;
            scaler_cnt <= '0;
            level <= 1'b1;       // first toggle is a falling edge
            cs <= 1'b0;
            state <= spi_pkg::IDLE;
            byte_cnt <= '0;
            gen_crc <= 1'b0;
            bit_cnt <= '0;
            tx_shift <= '1;      // mosi idles high
            rx_ready <= 1'b0;
            crc16 <= '0;
        end else begin
            if (tick) begin
                scaler_cnt <= '0;
                level <= !level;
            end else if (scaler != '0) begin
                scaler_cnt <= scaler_cnt + 32'd1;
            end

            if (sclk_fall && cs) begin
                tx_shift <= {tx_shift[6:0], 1'b1};
                if (bit_cnt != 3'd0) begin
                    bit_cnt <= bit_cnt - 3'd1;
                end else begin
                    cs <= 1'b0;  // kept active if WAIT_EDGE reloads below
                end
            end

            if (sclk_rise) begin
                rx_ready <= 1'b0;    // byte goes to the rx fifo on this edge
                if (cs) begin
                    crc16 <= crc16_nxt;
                end
            end

            if (fetch) begin
                byte_cnt <= byte_cnt - 16'd1;
            end

            case (state)
                spi_pkg::IDLE: begin
                    if (fetch) begin
                        state <= spi_pkg::WAIT_EDGE;
                    end
                end
                spi_pkg::WAIT_EDGE: begin
                    if (sclk_fall) begin
                        cs <= 1'b1;
                        bit_cnt <= 3'd7;
                        tx_shift <= tx_val;   // msb out on this edge
                        state <= spi_pkg::SEND_DATA;
                    end
                end
                spi_pkg::SEND_DATA: begin
                    if (last_bit) begin
                        rx_ready <= 1'b1;
                        if (fetch) begin
                            state <= spi_pkg::WAIT_EDGE;
                        end else if (gen_crc) begin
                            gen_crc <= 1'b0;  // one trailer per burst
                            state <= spi_pkg::WAIT_EDGE;
                        end else begin
                            state <= spi_pkg::ENDING;
                        end
                    end
                end
                spi_pkg::ENDING: begin
                    if (!cs) begin
                        state <= spi_pkg::IDLE;
                    end
                end
                default: state <= spi_pkg::IDLE;
            endcase

            // register writes take priority
            if (i_scaler_wr) begin
                scaler <= i_scaler;
                scaler_cnt <= '0;
            end
            if (i_txctrl_wr) begin
                byte_cnt <= i_byte_cnt;
                gen_crc <= i_gen_crc;
            end
            if (i_crc16_wr) begin
                crc16 <= i_crc16_wdata;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (fetch) begin
            tx_val <= fetch_byte;
        end else if (last_bit && gen_crc) begin
            tx_val <= {crc7_nxt, 1'b1};   // crc7 trailer with end bit
        end

        if ((state == spi_pkg::IDLE) && fetch) begin
            crc7 <= '0;
        end else if (sclk_rise && cs) begin
            crc7 <= crc7_nxt;
        end

        if (sclk_rise && cs) begin
            rx_shift <= {rx_shift[6:0], i_spi_miso};
        end
    end

    assign o_txfifo_re = fetch;
    assign o_rxfifo_we = sclk_rise && rx_ready;
    assign o_rxfifo_wdata = rx_shift;

    assign o_spi_cs_n = !cs;
    assign o_spi_sclk = level && cs;
    assign o_spi_mosi = tx_shift[7];

    assign o_byte_cnt = byte_cnt;
    assign o_gen_crc = gen_crc;
    assign o_state = state;
    assign o_crc16 = crc16;

    // serial clock only toggles inside an active burst
    a_sclk_in_burst: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_spi_sclk |-> (!o_spi_cs_n && (state != spi_pkg::IDLE)));

endmodule

`default_nettype wire

//--- apb_spi.sv
`default_nettype none

module apb_spi (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_psel,
    input  logic        i_penable,
    input  logic        i_pwrite,
    input  logic [31:0] i_paddr,
    input  logic [31:0] i_pwdata,
    output logic [31:0] o_prdata,
    output logic        o_pready,
    output logic        o_pslverr,
    output logic        o_spi_cs_n,
    output logic        o_spi_sclk,
    output logic        o_spi_mosi,
    input  logic        i_spi_miso,
    input  logic        i_card_detect,
    input  logic        i_write_protect
);

    logic req_valid;
    logic [31:0] req_addr;
    logic req_write;
    logic [31:0] req_wdata;
    logic [9:0] req_idx;
    logic wr_en;
    logic resp_valid;
    logic [31:0] resp_rdata;
    logic resp_err;
    logic [31:0] rdata;
    logic [31:0] sckdiv;         // read-back copy of the scaler
    logic scaler_wr;
    logic txctrl_wr;
    logic crc16_wr;
    logic [15:0] eng_byte_cnt;
    logic eng_gen_crc;
    spi_pkg::spi_state_e eng_state;
    logic [15:0] eng_crc16;
    logic tx_we;
    logic tx_re;
    logic [spi_pkg::FIFO_DBITS-1:0] tx_rdata;
    logic [spi_pkg::FIFO_CNT_BITS-1:0] tx_count;
    logic rx_we;
    logic rx_re;
    logic [spi_pkg::FIFO_DBITS-1:0] rx_wdata;
    logic [spi_pkg::FIFO_DBITS-1:0] rx_rdata;
    logic [spi_pkg::FIFO_CNT_BITS-1:0] rx_count;

    apb_slv u_apb_slv (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_psel       (i_psel),
        .i_penable    (i_penable),
        .i_pwrite     (i_pwrite),
        .i_paddr      (i_paddr),
        .i_pwdata     (i_pwdata),
        .o_prdata     (o_prdata),
        .o_pready     (o_pready),
        .o_pslverr    (o_pslverr),
        .o_req_valid  (req_valid),
        .o_req_addr   (req_addr),
        .o_req_write  (req_write),
        .o_req_wdata  (req_wdata),
        .i_resp_valid (resp_valid),
        .i_resp_rdata (resp_rdata),
        .i_resp_err   (resp_err)
    );

    // register decode
    assign req_idx = req_addr[11:2];
    assign wr_en = req_valid && req_write;
    assign scaler_wr = wr_en && (req_idx == spi_pkg::REG_SCKDIV);
    assign txctrl_wr = wr_en && (req_idx == spi_pkg::REG_TXCTRL);
    assign crc16_wr = wr_en && (req_idx == spi_pkg::REG_CRC16);
    assign tx_we = wr_en && (req_idx == spi_pkg::REG_TXDATA);
    assign rx_re = req_valid && !req_write && (req_idx == spi_pkg::REG_RXDATA);

    always_comb begin
        rdata = '0;
        case (req_idx)
            spi_pkg::REG_SCKDIV: rdata = sckdiv;
            spi_pkg::REG_TXCTRL: begin
                rdata[0] = i_card_detect;
                rdata[1] = i_write_protect;
                rdata[2] = i_spi_miso;
                rdata[5:4] = eng_state;
                rdata[7] = eng_gen_crc;
                rdata[31:16] = eng_byte_cnt;    // bytes still to send
            end
            spi_pkg::REG_TXDATA: rdata[31] = tx_count[spi_pkg::LOG2_FIFO_DEPTH];  // full
            spi_pkg::REG_RXDATA: begin
                rdata[7:0] = rx_rdata;          // head before the pop
                rdata[31] = (rx_count == '0);   // empty
            end
            spi_pkg::REG_CRC16: rdata[15:0] = eng_crc16;
            default: rdata = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            sckdiv <= '0;
            resp_valid <= 1'b0;
            resp_err <= 1'b0;
        end else begin
            if (scaler_wr) begin
                sckdiv <= req_wdata;
            end
            resp_valid <= req_valid;
            resp_err <= 1'b0;   // every offset answers
        end
    end

    always_ff @(posedge i_clk) begin
        resp_rdata <= rdata;
    end

    spi_engine u_engine (
        .i_clk          (i_clk),
        .i_nrst         (i_nrst),
        .i_scaler_wr    (scaler_wr),
        .i_scaler       (req_wdata),
        .i_txctrl_wr    (txctrl_wr),
        .i_byte_cnt     (req_wdata[31:16]),
        .i_gen_crc      (req_wdata[7]),
        .i_crc16_wr     (crc16_wr),
        .i_crc16_wdata  (req_wdata[15:0]),
        .o_byte_cnt     (eng_byte_cnt),
        .o_gen_crc      (eng_gen_crc),
        .o_state        (eng_state),
        .o_crc16        (eng_crc16),
        .o_txfifo_re    (tx_re),
        .i_txfifo_rdata (tx_rdata),
        .i_txfifo_count (tx_count),
        .o_rxfifo_we    (rx_we),
        .o_rxfifo_wdata (rx_wdata),
        .o_spi_cs_n     (o_spi_cs_n),
        .o_spi_sclk     (o_spi_sclk),
        .o_spi_mosi     (o_spi_mosi),
        .i_spi_miso     (i_spi_miso)
    );

    sfifo tx_fifo (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_we    (tx_we),
        .i_wdata (req_wdata[7:0]),
        .i_re    (tx_re),
        .o_rdata (tx_rdata),
        .o_count (tx_count)
    );

    sfifo rx_fifo (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_we    (rx_we),
        .i_wdata (rx_wdata),
        .i_re    (rx_re),
        .o_rdata (rx_rdata),
        .o_count (rx_count)
    );

endmodule

`default_nettype wire

//--- tb_spi_card.sv
`default_nettype none

module tb_spi_card (
    input  logic i_cs_n,
    input  logic i_sclk,
    input  logic i_mosi,
    output logic o_miso
);

    timeunit 1ns;
    timeprecision 1ps;

    integer seed;
    logic [7:0] out_byte;        // byte currently driven on miso
    logic [2:0] in_cnt;          // rising edges seen in the current byte
    logic [7:0] in_mosi;
    logic [7:0] in_miso;
    logic [7:0] mosi_bytes[$];   // bytes sent by the DUT
    logic [7:0] miso_bytes[$];   // bytes answered, as they were sampled

    initial begin
        seed = 35;
        o_miso = 1'b1;
        out_byte = 8'hff;
        in_cnt = 3'd0;
        in_mosi = 8'h00;
        in_miso = 8'h00;
    end

    // a new byte starts at chip select or after the 8th rising edge
    always @(negedge i_cs_n or negedge i_sclk) begin
        if (in_cnt == 3'd0) begin
            out_byte = 8'($random(seed));
            o_miso = out_byte[7];    // msb first
        end else begin
            o_miso = out_byte[3'd7 - in_cnt];
        end
    end

    always @(posedge i_sclk) begin
        in_mosi = {in_mosi[6:0], i_mosi};
        in_miso = {in_miso[6:0], o_miso};
        if (in_cnt == 3'd7) begin
            mosi_bytes.push_back(in_mosi);
            miso_bytes.push_back(in_miso);
        end
        in_cnt = in_cnt + 3'd1;  // wraps after a full byte
    end

endmodule

`default_nettype wire

//--- tb_apb_spi.sv
`default_nettype none

module tb_apb_spi;

    timeunit 1ns;
    timeprecision 1ps;

    logic clk;
    logic nrst;
    logic psel;
    logic penable;
    logic pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic cs_n;
    logic sclk;
    logic mosi;
    logic miso;
    logic card_detect;
    logic write_protect;

    integer seed;
    integer errors;
    integer checks;
    integer test_errors;         // error count at the start of a test
    integer tests_run;
    integer tests_failed;
    bit timed_out;
    logic [7:0] push_q[$];       // bytes for the next burst
    logic [7:0] rx_expect[$];    // bytes still expected from RXDATA

    apb_spi apb_spi_inst (
        .i_clk           (clk),
        .i_nrst          (nrst),
        .i_psel          (psel),
        .i_penable       (penable),
        .i_pwrite        (pwrite),
        .i_paddr         (paddr),
        .i_pwdata        (pwdata),
        .o_prdata        (prdata),
        .o_pready        (pready),
        .o_pslverr       (pslverr),
        .o_spi_cs_n      (cs_n),
        .o_spi_sclk      (sclk),
        .o_spi_mosi      (mosi),
        .i_spi_miso      (miso),
        .i_card_detect   (card_detect),
        .i_write_protect (write_protect)
    );

    tb_spi_card u_card (
        .i_cs_n (cs_n),
        .i_sclk (sclk),
        .i_mosi (mosi),
        .o_miso (miso)
    );

    always #20 clk = ~clk;

    // crc7 x^7+x^3+1, msb first
    function automatic logic [6:0] crc7_byte(input logic [6:0] crc, input logic [7:0] b);
        logic [6:0] c;
        logic fb;
        c = crc;
        for (int i = 7; i >= 0; i--) begin
            fb = c[6] ^ b[i];
            c = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return c;
    endfunction

    // crc16 x^16+x^12+x^5+1, msb first
    function automatic logic [15:0] crc16_byte(input logic [15:0] crc, input logic [7:0] b);
        logic [15:0] c;
        logic fb;
        c = crc;
        for (int i = 7; i >= 0; i--) begin
            fb = c[15] ^ b[i];
            c = {c[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
        end
        return c;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s at %0t ns", what, $time);
        timed_out = 1'b1;
    endtask

    task automatic apb_transfer(input logic write, input logic [9:0] idx,
                                input logic [31:0] wdata, output logic [31:0] rdata);
        int n;
        rdata = '0;
        @(negedge clk);
        psel = 1'b1;
        pwrite = write;
        paddr = {20'h0, idx, 2'b00};
        pwdata = wdata;
        @(negedge clk);
        penable = 1'b1;
        n = 0;
        @(negedge clk);
        while (!pready && n < 16) begin
            @(negedge clk);
            n++;
        end
        if (pready) begin
            rdata = prdata;
            check_value("pslverr", 32'(pslverr), 32'd0);   // every offset answers
        end else begin
            report_timeout("pready");
        end
        @(negedge clk);    // transfer completes on the edge in between
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_write(input logic [9:0] idx, input logic [31:0] data);
        logic [31:0] unused;
        apb_transfer(1'b1, idx, data, unused);
    endtask

    task automatic apb_read(input logic [9:0] idx, output logic [31:0] data);
        apb_transfer(1'b0, idx, 32'h0, data);
    endtask

    task automatic wait_idle();
        logic [31:0] r;
        int n;
        n = 0;
        apb_read(spi_pkg::REG_TXCTRL, r);
        while ((r[5:4] != spi_pkg::IDLE || r[31:16] != 16'h0) && n < 2000 && !timed_out) begin
            apb_read(spi_pkg::REG_TXCTRL, r);
            n++;
        end
        if (r[5:4] != spi_pkg::IDLE || r[31:16] != 16'h0) begin
            report_timeout("the engine to return to idle");
        end
    endtask

    task automatic read_rx_byte(output logic [7:0] b);
        logic [31:0] r;
        int n;
        n = 0;
        apb_read(spi_pkg::REG_RXDATA, r);
        while (r[31] && n < 100 && !timed_out) begin   // push latency varies
            apb_read(spi_pkg::REG_RXDATA, r);
            n++;
        end
        if (r[31]) begin
            report_timeout("a byte in the receive FIFO");
        end
        b = r[7:0];
    endtask

    task automatic fill_push(input int n);
        for (int i = 0; i < n; i++) begin
            push_q.push_back(8'($random(seed)));
        end
    endtask

    // pushed bytes, then 0xff fill, then the optional crc7 trailer
    task automatic run_burst(input int total, input logic gen);
        logic [7:0] exp_q[$];
        logic [6:0] crc;
        crc = 7'h00;
        u_card.mosi_bytes.delete();
        u_card.miso_bytes.delete();
        for (int i = 0; i < push_q.size(); i++) begin
            apb_write(spi_pkg::REG_TXDATA, {24'h0, push_q[i]});
        end
        for (int i = 0; i < total; i++) begin
            exp_q.push_back((i < push_q.size()) ? push_q[i] : 8'hff);
            crc = crc7_byte(crc, exp_q[i]);
        end
        if (gen) begin
            exp_q.push_back({crc, 1'b1});
        end
        apb_write(spi_pkg::REG_SCKDIV, 32'd2);
        apb_write(spi_pkg::REG_TXCTRL, {total[15:0], 8'h00, gen, 7'h00});
        wait_idle();
        check_value("bytes seen by the card", 32'(u_card.mosi_bytes.size()),
                    32'(exp_q.size()));
        for (int i = 0; i < exp_q.size() && i < u_card.mosi_bytes.size(); i++) begin
            check_value($sformatf("card byte %0d", i), 32'(u_card.mosi_bytes[i]),
                        32'(exp_q[i]));
        end
        for (int i = 0; i < u_card.miso_bytes.size(); i++) begin
            rx_expect.push_back(u_card.miso_bytes[i]);
        end
        push_q.delete();
    endtask

    task automatic check_receive();
        logic [7:0] b;
        logic [31:0] r;
        for (int i = 0; i < rx_expect.size(); i++) begin
            read_rx_byte(b);
            check_value($sformatf("rx byte %0d", i), 32'(b), 32'(rx_expect[i]));
        end
        apb_read(spi_pkg::REG_RXDATA, r);
        check_value("rx empty flag", 32'(r[31]), 32'd1);
        rx_expect.delete();
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != test_errors || timed_out) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - test_errors);
        end else begin
            $display("test %s: passed", name);
        end
        test_errors = errors;
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] w;
        logic [15:0] crc16;
        int n;
        seed = 35;
        errors = 0;
        checks = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        timed_out = 1'b0;
        clk = 1'b0;
        nrst = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = 32'h0;
        pwdata = 32'h0;
        card_detect = 1'b0;
        write_protect = 1'b0;
        repeat (16) @(negedge clk);
        nrst = 1'b1;

        check_value("cs_n after reset", 32'(cs_n), 32'd1);
        check_value("sclk after reset", 32'(sclk), 32'd0);
        check_value("mosi after reset", 32'(mosi), 32'd1);
        check_value("pready after reset", 32'(pready), 32'd0);
        for (int i = 0; i < 4 && !timed_out; i++) begin
            @(negedge clk);
            card_detect = 1'($random(seed));
            write_protect = 1'($random(seed));
            w = $random(seed);
            apb_write(spi_pkg::REG_SCKDIV, w);
            apb_read(spi_pkg::REG_SCKDIV, r);
            check_value("sckdiv readback", r, w);
            w = {16'h0, 16'($random(seed))};   // byte count 0, no burst
            apb_write(spi_pkg::REG_TXCTRL, w);
            apb_read(spi_pkg::REG_TXCTRL, r);
            check_value("txctrl readback", r, {16'h0, 8'h0, w[7], 1'b0, 2'b00, 1'b0,
                                               miso, write_protect, card_detect});
        end
        finish_test("register readback");

        if (!timed_out) begin
            n = 1 + int'($unsigned($random(seed)) % 8);
            fill_push(n);
            run_burst(n, 1'b0);
        end
        finish_test("transmit burst");

        // second burst on top of the first, both drained in order
        if (!timed_out) begin
            n = 1 + int'($unsigned($random(seed)) % 6);
            fill_push(n);
            run_burst(n, 1'b0);
            check_receive();
        end
        finish_test("receive path");

        if (!timed_out) begin
            n = 1 + int'($unsigned($random(seed)) % 3);
            fill_push(n);
            run_burst(n + 1 + int'($unsigned($random(seed)) % 4), 1'b0);
            check_receive();
        end
        finish_test("empty fifo fill");

        if (!timed_out) begin
            apb_write(spi_pkg::REG_CRC16, 32'h0);
            n = 1 + int'($unsigned($random(seed)) % 8);
            fill_push(n);
            run_burst(n, 1'b1);
            crc16 = 16'h0;
            for (int i = 0; i < u_card.miso_bytes.size(); i++) begin
                crc16 = crc16_byte(crc16, u_card.miso_bytes[i]);
            end
            apb_read(spi_pkg::REG_CRC16, r);
            check_value("crc16 over miso", r, {16'h0, crc16});
            check_receive();
        end
        finish_test("crc7 and crc16");

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0 && !timed_out) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
spi_pkg.sv
sfifo.sv
apb_slv.sv
spi_engine.sv
apb_spi.sv
tb_spi_card.sv
tb_apb_spi.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_apb_spi
FILELIST  = verilog.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | awk '{ print } /^SIMULATION PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
